// File: hdl/mchan_ctrl_pkg.sv
// Widths, register offsets, command field positions, target and command structs, response kinds
`default_nettype none

package mchan_ctrl_pkg;

   // *******************************************************************
   // Widths
   // *******************************************************************
   localparam int unsigned NB_TRANSFERS     = 4;
   localparam int unsigned SID_W            = 2;    // Enough for NB_TRANSFERS slots
   localparam int unsigned PE_ID_W          = 1;
   localparam int unsigned TCDM_ADD_W       = 12;
   localparam int unsigned EXT_ADD_W        = 29;
   localparam int unsigned LEN_FIELD_W      = 16;   // Length in 8 byte units
   localparam int unsigned CMD_LEN_W        = 19;   // Length in bytes minus one
   localparam int unsigned LEN_SHIFT        = CMD_LEN_W - LEN_FIELD_W;

   // Allocation status sits in the upper half of the status word
   localparam int unsigned STATUS_ALLOC_LSB = 16;

   // *******************************************************************
   // Command word layout
   // *******************************************************************
   localparam int unsigned OPC_BIT = 16;   // Direction
   localparam int unsigned INC_BIT = 17;   // Incremental addressing
   localparam int unsigned ELE_BIT = 19;   // Event lines enable
   localparam int unsigned ILE_BIT = 20;   // Interrupt lines enable
   localparam int unsigned BLE_BIT = 21;   // Broadcast enable

   // Register offsets, decoded from address bits 3:2
   localparam logic [1:0] REG_CMD    = 2'd0;
   localparam logic [1:0] REG_STATUS = 2'd1;

   // *******************************************************************
   // Target access and response
   // *******************************************************************
   typedef struct packed {
      logic               req;
      logic               rd;     // 1 for read
      logic [31:0]        addr;
      logic [31:0]        data;
      logic [PE_ID_W-1:0] id;
   } ctrl_req_t;

   typedef struct packed {
      logic               r_valid;
      logic [31:0]        r_data;
      logic [PE_ID_W-1:0] r_id;
   } ctrl_rsp_t;

   // *******************************************************************
   // Command queue entry
   // *******************************************************************
   typedef struct packed {
      logic [CMD_LEN_W-1:0] len;
      logic                 opc;
      logic                 inc;
      logic                 ele;
      logic                 ile;
      logic                 ble;
      logic [SID_W-1:0]     sid;
   } dma_cmd_t;

   // What the response cycle returns
   typedef enum logic [1:0] {
      RSP_ACK,
      RSP_SID,
      RSP_STATUS
   } rsp_kind_e;

endpackage

`default_nettype wire

// File: hdl/mchan_sid_tracker.sv
// SID register and completion detection for the armed transfer
`default_nettype none

module mchan_sid_tracker (
   input  logic                                    clk_i,
   input  logic                                    rst_ni,
   input  logic                                    sid_load_i,
   input  logic [mchan_ctrl_pkg::SID_W-1:0]        trans_alloc_ret_i,
   input  logic                                    arm_i,
   input  logic                                    arb_req_i,
   input  logic                                    arb_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_W-1:0]        arb_sid_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_status_i,
   output logic [mchan_ctrl_pkg::SID_W-1:0]        sid_o,
   output logic                                    done_o
);

   import mchan_ctrl_pkg::*;

   logic [SID_W-1:0] sid_q;
   logic             armed_q;   // Transfer queued, watching arbiter
   logic             seen_q;    // Arbiter has granted our SID
   logic             arb_hit;

   assign arb_hit = armed_q && arb_req_i && arb_gnt_i && (arb_sid_i == sid_q);
   assign done_o  = seen_q && trans_status_i[sid_q];

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         sid_q   <= '0;
         armed_q <= 1'b0;
         seen_q  <= 1'b0;
      end
      else
      begin
         if (sid_load_i)
         begin
            sid_q <= trans_alloc_ret_i;
         end
         if (done_o)
         begin
            armed_q <= 1'b0;   // Ready for the next transfer
            seen_q  <= 1'b0;
         end
         else
         begin
            if (arm_i)
            begin
               armed_q <= 1'b1;
            end
            if (arb_hit)
            begin
               seen_q <= 1'b1;
            end
         end
      end
   end

   assign sid_o = sid_q;

   // A new transfer must not inherit a stale arbiter match
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      arm_i |-> !(seen_q && !done_o))
      else $error("arm while previous transfer still pending");

endmodule

`default_nettype wire

// File: hdl/mchan_resp_gen.sv
// Target response generator: one registered response per granted access
`default_nettype none

module mchan_resp_gen (
   input  logic                                    clk_i,
   input  logic                                    rst_ni,
   input  logic                                    gnt_i,
   input  mchan_ctrl_pkg::rsp_kind_e               rsp_kind_i,
   input  logic [mchan_ctrl_pkg::PE_ID_W-1:0]      req_id_i,
   input  logic [mchan_ctrl_pkg::SID_W-1:0]        sid_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_status_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_alloc_status_i,
   output mchan_ctrl_pkg::ctrl_rsp_t               rsp_o
);

   import mchan_ctrl_pkg::*;

   logic               valid_q;
   rsp_kind_e          kind_q;
   logic [PE_ID_W-1:0] id_q;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         valid_q <= 1'b0;
         kind_q  <= RSP_ACK;
         id_q    <= '0;
      end
      else
      begin
         valid_q <= gnt_i;   // Response follows each grant
         if (gnt_i)
         begin
            kind_q <= rsp_kind_i;
            id_q   <= req_id_i;
         end
      end
   end

   // Status and SID are sampled in the response cycle itself
   always_comb
   begin
      rsp_o.r_valid = valid_q;
      rsp_o.r_id    = id_q;
      rsp_o.r_data  = '0;
      if (valid_q)
      begin
         case (kind_q)
            RSP_SID:
            begin
               rsp_o.r_data[SID_W-1:0] = sid_i;
            end
            RSP_STATUS:
            begin
               rsp_o.r_data[NB_TRANSFERS-1:0]                   = trans_status_i;
               rsp_o.r_data[STATUS_ALLOC_LSB +: NB_TRANSFERS]   = trans_alloc_status_i;
            end
            default:
            begin
               rsp_o.r_data = '0;   // Plain write ack
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/mchan_ctrl_fsm.sv
// Programming sequencer: register decode, target grant and downstream request generation
`default_nettype none

module mchan_ctrl_fsm (
   input  logic                                  clk_i,
   input  logic                                  rst_ni,

   // Register target
   input  mchan_ctrl_pkg::ctrl_req_t             ctrl_req_i,
   output logic                                  gnt_o,
   output mchan_ctrl_pkg::rsp_kind_e             rsp_kind_o,

   // Downstream queues
   input  logic                                  cmd_gnt_i,
   input  logic                                  tcdm_gnt_i,
   input  logic                                  ext_gnt_i,
   output logic                                  cmd_req_o,
   output logic                                  tcdm_req_o,
   output logic                                  ext_req_o,

   // Transfer allocator
   input  logic                                  trans_alloc_gnt_i,
   output logic                                  trans_alloc_req_o,
   output logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_alloc_clr_o,

   // SID tracker
   input  logic                                  done_i,
   output logic                                  sid_load_o,
   output logic                                  arm_o,

   output logic                                  busy_o
);

   import mchan_ctrl_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      TCDM_WAIT,
      EXT_WAIT,
      XFER_WAIT
   } state_e;

   state_e     state_q, state_d;
   logic [1:0] offset;
   logic       cmd_wr;

   assign offset = ctrl_req_i.addr[3:2];
   assign cmd_wr = !ctrl_req_i.rd && (offset == REG_CMD);   // Only access legal mid sequence

   // *******************************************************************
   // State register
   // *******************************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // *******************************************************************
   // Decode and next state
   // *******************************************************************
   always_comb
   begin
      state_d           = state_q;
      gnt_o             = 1'b0;
      rsp_kind_o        = RSP_ACK;
      trans_alloc_req_o = 1'b0;
      trans_alloc_clr_o = '0;
      cmd_req_o         = 1'b0;
      tcdm_req_o        = 1'b0;
      ext_req_o         = 1'b0;
      sid_load_o        = 1'b0;
      arm_o             = 1'b0;

      case (state_q)
         IDLE:
         begin
            if (ctrl_req_i.req)
            begin
               case (offset)
                  REG_CMD:
                  begin
                     if (ctrl_req_i.rd)
                     begin
                        trans_alloc_req_o = 1'b1;              // Ask allocator for a SID
                        if (trans_alloc_gnt_i)
                        begin
                           gnt_o      = 1'b1;
                           sid_load_o = 1'b1;
                           rsp_kind_o = RSP_SID;
                        end
                     end
                     else if (cmd_gnt_i)
                     begin
                        gnt_o     = 1'b1;
                        cmd_req_o = 1'b1;
                        state_d   = TCDM_WAIT;
                     end
                  end
                  REG_STATUS:
                  begin
                     gnt_o = 1'b1;                             // Never stalls
                     if (ctrl_req_i.rd)
                     begin
                        rsp_kind_o = RSP_STATUS;
                     end
                     else
                     begin
                        trans_alloc_clr_o = ctrl_req_i.data[NB_TRANSFERS-1:0];
                     end
                  end
                  default:
                  begin
                     state_d = IDLE;                           // Unmapped offset
                  end
               endcase
            end
         end

         TCDM_WAIT:
         begin
            if (ctrl_req_i.req)
            begin
               if (!cmd_wr)
               begin
                  state_d = IDLE;                              // Abort sequence
               end
               else if (tcdm_gnt_i)
               begin
                  gnt_o      = 1'b1;
                  tcdm_req_o = 1'b1;
                  state_d    = EXT_WAIT;
               end
            end
         end

         EXT_WAIT:
         begin
            if (ctrl_req_i.req)
            begin
               if (!cmd_wr)
               begin
                  state_d = IDLE;                              // Abort sequence
               end
               else if (ext_gnt_i)
               begin
                  gnt_o     = 1'b1;
                  ext_req_o = 1'b1;
                  arm_o     = 1'b1;                            // Transfer fully queued
                  state_d   = XFER_WAIT;
               end
            end
         end

         XFER_WAIT:
         begin
            if (done_i)
            begin
               state_d = IDLE;
            end
         end

         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

   assign busy_o = (state_q != IDLE);

   // *******************************************************************
   // Checks
   // *******************************************************************
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({cmd_req_o, tcdm_req_o, ext_req_o}))
      else $error("more than one downstream request active");

   assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt_o |-> ctrl_req_i.req)
      else $error("target grant without request");

endmodule

`default_nettype wire

// File: hdl/mchan_ctrl_top.sv
// Control unit top level: sequencer, SID tracker, response generator and command field slicing
`default_nettype none

module mchan_ctrl_top (
   input  logic                                    clk_i,
   input  logic                                    rst_ni,

   // Register target
   input  mchan_ctrl_pkg::ctrl_req_t               ctrl_req_i,
   output logic                                    gnt_o,
   output mchan_ctrl_pkg::ctrl_rsp_t               ctrl_rsp_o,

   // Command, TCDM and external address queues
   input  logic                                    cmd_gnt_i,
   output logic                                    cmd_req_o,
   output mchan_ctrl_pkg::dma_cmd_t                cmd_o,
   input  logic                                    tcdm_gnt_i,
   output logic                                    tcdm_req_o,
   output logic [mchan_ctrl_pkg::TCDM_ADD_W-1:0]   tcdm_add_o,
   input  logic                                    ext_gnt_i,
   output logic                                    ext_req_o,
   output logic [mchan_ctrl_pkg::EXT_ADD_W-1:0]    ext_add_o,

   // Synchronisation arbiter
   input  logic                                    arb_req_i,
   input  logic                                    arb_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_W-1:0]        arb_sid_i,

   // Transfer allocator and status
   output logic                                    trans_alloc_req_o,
   input  logic                                    trans_alloc_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_W-1:0]        trans_alloc_ret_i,
   output logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_alloc_clr_o,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_alloc_status_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_status_i,

   output logic                                    busy_o
);

   import mchan_ctrl_pkg::*;

   rsp_kind_e        rsp_kind;
   logic             sid_load;
   logic             arm;
   logic             done;
   logic [SID_W-1:0] sid;

   mchan_ctrl_fsm fsm_i (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .ctrl_req_i        (ctrl_req_i),
      .gnt_o             (gnt_o),
      .rsp_kind_o        (rsp_kind),
      .cmd_gnt_i         (cmd_gnt_i),
      .tcdm_gnt_i        (tcdm_gnt_i),
      .ext_gnt_i         (ext_gnt_i),
      .cmd_req_o         (cmd_req_o),
      .tcdm_req_o        (tcdm_req_o),
      .ext_req_o         (ext_req_o),
      .trans_alloc_gnt_i (trans_alloc_gnt_i),
      .trans_alloc_req_o (trans_alloc_req_o),
      .trans_alloc_clr_o (trans_alloc_clr_o),
      .done_i            (done),
      .sid_load_o        (sid_load),
      .arm_o             (arm),
      .busy_o            (busy_o)
   );

   mchan_sid_tracker tracker_i (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .sid_load_i        (sid_load),
      .trans_alloc_ret_i (trans_alloc_ret_i),
      .arm_i             (arm),
      .arb_req_i         (arb_req_i),
      .arb_gnt_i         (arb_gnt_i),
      .arb_sid_i         (arb_sid_i),
      .trans_status_i    (trans_status_i),
      .sid_o             (sid),
      .done_o            (done)
   );

   mchan_resp_gen resp_i (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .gnt_i                (gnt_o),
      .rsp_kind_i           (rsp_kind),
      .req_id_i             (ctrl_req_i.id),
      .sid_i                (sid),
      .trans_status_i       (trans_status_i),
      .trans_alloc_status_i (trans_alloc_status_i),
      .rsp_o                (ctrl_rsp_o)
   );

   // *******************************************************************
   // Command word and address slicing
   // *******************************************************************
   assign cmd_o.len  = {ctrl_req_i.data[LEN_FIELD_W-1:0], {LEN_SHIFT{1'b0}}} - CMD_LEN_W'(1);
   assign cmd_o.opc  = ctrl_req_i.data[OPC_BIT];
   assign cmd_o.inc  = ctrl_req_i.data[INC_BIT];
   assign cmd_o.ele  = ctrl_req_i.data[ELE_BIT];
   assign cmd_o.ile  = ctrl_req_i.data[ILE_BIT];
   assign cmd_o.ble  = ctrl_req_i.data[BLE_BIT];
   assign cmd_o.sid  = sid;                                    // From last SID read

   assign tcdm_add_o = ctrl_req_i.data[TCDM_ADD_W-1:0];
   assign ext_add_o  = ctrl_req_i.data[EXT_ADD_W-1:0];

endmodule

`default_nettype wire

// File: testbench/mchan_ctrl_tb.sv
// DMA control unit testbench with stimulus table, allocator and arbiter stubs and response checker
`default_nettype none

module mchan_ctrl_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import mchan_ctrl_pkg::*;

   localparam int TIMEOUT = 64;   // Cycles allowed per wait
   localparam int W_EXT   = 0;    // Downstream queue selectors
   localparam int W_TCDM  = 1;
   localparam int W_CMD   = 2;
   localparam int NB_ROWS = 7;

   typedef enum {K_STAT_RD, K_STAT_WR, K_SID_RD, K_SEQ, K_ABORT} kind_e;

   typedef struct {
      string       name;
      kind_e       kind;
      logic [31:0] data;       // Command flags, clear mask or status stimulus
      int          stall;      // Downstream or allocator grant stall
      int          arb_dly;
      int          stat_dly;
      logic [31:0] exp;        // Expected response data
   } row_t;

   logic                    clk_i = 1'b0;
   logic                    rst_ni;
   ctrl_req_t               ctrl_req_i;
   ctrl_rsp_t               ctrl_rsp_o;
   dma_cmd_t                cmd_o;
   logic                    gnt_o;
   logic                    cmd_gnt_i, tcdm_gnt_i, ext_gnt_i;
   logic                    cmd_req_o, tcdm_req_o, ext_req_o;
   logic [TCDM_ADD_W-1:0]   tcdm_add_o;
   logic [EXT_ADD_W-1:0]    ext_add_o;
   logic                    arb_req_i, arb_gnt_i;
   logic [SID_W-1:0]        arb_sid_i, trans_alloc_ret_i;
   logic                    trans_alloc_req_o, trans_alloc_gnt_i;
   logic [NB_TRANSFERS-1:0] trans_alloc_clr_o, trans_alloc_status_i, trans_status_i;
   logic                    busy_o;

   row_t                    table_q [NB_ROWS];
   int                      seed;
   string                   cur_name;
   logic [PE_ID_W-1:0]      cur_id;
   logic [SID_W-1:0]        next_sid;   // Allocator stub counter
   ctrl_rsp_t               exp_rsp, due_rsp;
   logic                    exp_pend = 1'b0;
   logic                    due_pend = 1'b0;

   mchan_ctrl_top dut_i (.*);

   always #50 clk_i = ~clk_i;

   // *********************************************************************
   // Failure reporting and compare tasks
   // *********************************************************************
   task automatic stop_run();
      $display("sim failed");
      $fatal(1, "run stopped");
   endtask

   task automatic fail_now(input string what);
      $display("%s in test %s", what, cur_name);
      stop_run();
   endtask

   task automatic check_rsp(input string name, input ctrl_rsp_t exp, input ctrl_rsp_t act);
      if (act !== exp)
      begin
         $display("error %s: expected response %h, actual %h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_cmd(input string name, input dma_cmd_t exp, input dma_cmd_t act);
      if (act !== exp)
      begin
         $display("error %s: expected command %h, actual %h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_bits(input string name, input logic [NB_TRANSFERS-1:0] exp,
                             input logic [NB_TRANSFERS-1:0] act);
      if (act !== exp)
      begin
         $display("error %s: expected bits %b, actual %b", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_addr(input string name, input logic [EXT_ADD_W-1:0] exp,
                             input logic [EXT_ADD_W-1:0] act);
      if (act !== exp)
      begin
         $display("error %s: expected address %h, actual %h", name, exp, act);
         stop_run();
      end
   endtask

   // Response due exactly one cycle after each grant
   always @(posedge clk_i)
   begin
      due_rsp  = exp_rsp;
      due_pend = exp_pend;
      exp_pend = 1'b0;
   end

   always @(negedge clk_i)
   begin
      if (due_pend)
         check_rsp(cur_name, due_rsp, ctrl_rsp_o);
      else if (ctrl_rsp_o.r_valid)
         fail_now("response without a granted access");
   end

   // *********************************************************************
   // Stimulus tasks
   // *********************************************************************
   task automatic step();
      @(posedge clk_i);
      #10;
   endtask

   task automatic idle_inputs();
      ctrl_req_i        = '0;
      cmd_gnt_i         = 1'b0;
      tcdm_gnt_i        = 1'b0;
      ext_gnt_i         = 1'b0;
      trans_alloc_gnt_i = 1'b0;
      arb_req_i         = 1'b0;
      arb_gnt_i         = 1'b0;
   endtask

   task automatic drive_req(input logic rd, input logic [1:0] off, input logic [31:0] data);
      ctrl_req_i.req  = 1'b1;
      ctrl_req_i.rd   = rd;
      ctrl_req_i.addr = 32'h1020_0000 | {28'h0, off, 2'b00};
      ctrl_req_i.data = data;
      ctrl_req_i.id   = cur_id;
   endtask

   // Ends on the falling edge of the grant cycle and books the response
   task automatic wait_grant(input logic [31:0] exp_data);
      int n;
      n = 0;
      @(negedge clk_i);
      while (!gnt_o)
      begin
         if (n == TIMEOUT)
            fail_now("timeout waiting for the target grant");
         step();
         @(negedge clk_i);
         n++;
      end
      exp_rsp.r_valid = 1'b1;
      exp_rsp.r_data  = exp_data;
      exp_rsp.r_id    = ctrl_req_i.id;
      exp_pend        = 1'b1;
   endtask

   task automatic alloc_sid(input int withhold, output logic [SID_W-1:0] sid);
      int i;
      trans_alloc_gnt_i = 1'b0;
      drive_req(1'b1, REG_CMD, '0);
      for (i = 0; i < withhold; i++)
      begin
         @(negedge clk_i);
         if (gnt_o || !trans_alloc_req_o)
            fail_now("SID read granted or not requested while allocator withholds");
         step();
      end
      trans_alloc_gnt_i = 1'b1;
      trans_alloc_ret_i = next_sid;
      sid               = next_sid;
      next_sid++;
      wait_grant(32'(sid));
   endtask

   task automatic push_word(input int which, input logic [31:0] data, input int stall);
      int i;
      trans_alloc_gnt_i = 1'b0;
      cmd_gnt_i         = 1'b0;
      tcdm_gnt_i        = 1'b0;
      ext_gnt_i         = 1'b0;
      drive_req(1'b0, REG_CMD, data);
      for (i = 0; i < stall; i++)
      begin
         @(negedge clk_i);
         if (gnt_o || cmd_req_o || tcdm_req_o || ext_req_o)
            fail_now("access went through under back-pressure");
         step();
      end
      cmd_gnt_i  = (which == W_CMD);
      tcdm_gnt_i = (which == W_TCDM);
      ext_gnt_i  = (which == W_EXT);
      wait_grant('0);
      check_bits(cur_name, 4'(1 << which), {1'b0, cmd_req_o, tcdm_req_o, ext_req_o});
   endtask

   task automatic run_seq(input row_t row);
      logic [SID_W-1:0] sid;
      logic [31:0]      word;
      dma_cmd_t         exp_cmd;
      int               c;
      int               last;
      logic             busy_low;
      trans_status_i = '0;
      alloc_sid(0, sid);
      step();
      word        = $random(seed);
      word        = {row.data[31:16], word[15:0]};
      exp_cmd.len = 19'(word[15:0]) * 19'd8 - 19'd1;   // Length field in bytes minus one
      exp_cmd.opc = word[16];
      exp_cmd.inc = word[17];
      exp_cmd.ele = word[19];
      exp_cmd.ile = word[20];
      exp_cmd.ble = word[21];
      exp_cmd.sid = sid;
      push_word(W_CMD, word, row.stall);
      check_cmd(row.name, exp_cmd, cmd_o);
      step();
      word = $random(seed);
      push_word(W_TCDM, word, row.stall);
      check_addr(row.name, EXT_ADD_W'(word[11:0]), EXT_ADD_W'(tcdm_add_o));
      step();
      word = $random(seed);
      push_word(W_EXT, word, row.stall);
      check_addr(row.name, word[28:0], ext_add_o);
      step();
      idle_inputs();
      // Done needs the registered arbiter match and the status bit
      last      = (row.arb_dly + 1 > row.stat_dly) ? row.arb_dly + 1 : row.stat_dly;
      c         = 0;
      busy_low  = 1'b0;
      while (!busy_low)
      begin
         arb_req_i           = (c <= row.arb_dly);
         arb_gnt_i           = (c <= row.arb_dly);
         arb_sid_i           = (c == row.arb_dly) ? sid : sid + 1'b1;   // Other SIDs first
         trans_status_i[sid] = (c >= row.stat_dly);
         @(negedge clk_i);
         if (!busy_o)
            busy_low = 1'b1;
         else if (c == TIMEOUT)
            fail_now("timeout waiting for busy to fall");
         else
         begin
            step();
            c++;
         end
      end
      if (c != last + 1)
         fail_now("busy fell before or after the transfer completed");
   endtask

   task automatic run_abort(input row_t row);
      logic [SID_W-1:0] sid;
      logic [31:0]      word;
      alloc_sid(0, sid);
      step();
      word = $random(seed);
      push_word(W_CMD, word, 0);
      step();
      idle_inputs();
      trans_status_i       = row.data[3:0];
      trans_alloc_status_i = row.data[7:4];
      drive_req(1'b1, REG_STATUS, '0);
      @(negedge clk_i);
      if (gnt_o || !busy_o)
         fail_now("read granted in the middle of a sequence");
      step();
      wait_grant(row.exp);   // Same read granted back in idle
      if (busy_o)
         fail_now("busy still high after the aborted sequence");
   endtask

   // *********************************************************************
   // Table and main loop
   // *********************************************************************
   initial
   begin
      int r;
      table_q[0] = '{"stat_rd", K_STAT_RD, 32'h0000_00a5, 0, 0, 0, 32'h000a_0005};
      table_q[1] = '{"stat_wr", K_STAT_WR, 32'h0000_0009, 0, 0, 0, 32'h0};
      table_q[2] = '{"sid_rd", K_SID_RD, 32'h0, 3, 0, 0, 32'h0};
      table_q[3] = '{"seq_arb_first", K_SEQ, 32'h0067_0000, 0, 1, 4, 32'h0};
      table_q[4] = '{"seq_stat_first", K_SEQ, 32'h0018_0000, 0, 5, 2, 32'h0};
      table_q[5] = '{"seq_stall", K_SEQ, 32'h0001_0000, 3, 2, 2, 32'h0};
      table_q[6] = '{"abort", K_ABORT, 32'h0000_0036, 0, 0, 0, 32'h0003_0006};
      seed                 = 32'h8fff;
      next_sid             = '0;
      cur_name             = "reset";
      cur_id               = '0;
      rst_ni               = 1'b0;
      arb_sid_i            = '0;
      trans_alloc_ret_i    = '0;
      trans_alloc_status_i = '0;
      trans_status_i       = '0;
      idle_inputs();
      repeat (15) @(posedge clk_i);
      @(negedge clk_i);
      if (gnt_o || ctrl_rsp_o.r_valid || cmd_req_o || tcdm_req_o || ext_req_o ||
          trans_alloc_req_o || (trans_alloc_clr_o != '0) || busy_o)
         fail_now("outputs not low during reset");
      step();
      rst_ni = 1'b1;
      step();
      for (r = 0; r < NB_ROWS; r++)
      begin
         cur_name = table_q[r].name;
         cur_id   = PE_ID_W'(r);
         case (table_q[r].kind)
            K_STAT_RD:
            begin
               trans_status_i       = table_q[r].data[3:0];
               trans_alloc_status_i = table_q[r].data[7:4];
               drive_req(1'b1, REG_STATUS, '0);
               wait_grant(table_q[r].exp);
            end
            K_STAT_WR:
            begin
               drive_req(1'b0, REG_STATUS, table_q[r].data);
               wait_grant(table_q[r].exp);
               check_bits(cur_name, table_q[r].data[3:0], trans_alloc_clr_o);
            end
            K_SID_RD:
            begin
               alloc_sid(table_q[r].stall, arb_sid_i);
            end
            K_SEQ:
            begin
               run_seq(table_q[r]);
            end
            default:
            begin
               run_abort(table_q[r]);
            end
         endcase
         step();
         idle_inputs();
         @(negedge clk_i);              // Last response checked here
         check_bits(cur_name, '0, trans_alloc_clr_o);
         step();
      end
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
hdl/mchan_ctrl_pkg.sv
hdl/mchan_sid_tracker.sv
hdl/mchan_resp_gen.sv
hdl/mchan_ctrl_fsm.sv
hdl/mchan_ctrl_top.sv
testbench/mchan_ctrl_tb.sv
